/* src/gng_num_pkg.sv */
package gng_num_pkg;

    localparam int URNG_W   = 64;
    localparam int X_W      = 15;   // u<15,15>
    localparam int C0_W     = 18;   // u<18,14>
    localparam int C1_W     = 18;   // s<18,19>
    localparam int C2_W     = 17;   // u<17,23>
    localparam int MAG_W    = 15;   // u<15,11>
    localparam int SAMPLE_W = 16;   // s<16,11>

    // x*c2 + c1*2^19, then keep the top part as t
    localparam int PROD1_W  = X_W + C2_W;
    localparam int C1_SHIFT = 19;
    localparam int SUM1_W   = 38;
    localparam int T_LSB    = 20;
    localparam int T_W      = 18;

    // x*t, then c0 + m and round
    localparam int PROD2_W  = X_W + 1 + T_W;
    localparam int M_LSB    = 19;
    localparam int M_W      = 14;
    localparam int SUM2_W   = C0_W + 1;
    localparam int RND_LSB  = 3;

    typedef logic        [URNG_W-1:0]   urng_t;
    typedef logic        [X_W-1:0]      x_t;
    typedef logic        [C0_W-1:0]     c0_t;
    typedef logic signed [C1_W-1:0]     c1_t;
    typedef logic        [C2_W-1:0]     c2_t;
    typedef logic        [MAG_W-1:0]    mag_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef logic        [PROD1_W-1:0]  prod1_t;
    typedef logic signed [SUM1_W-1:0]   sum1_t;
    typedef logic signed [T_W-1:0]      t_t;
    typedef logic signed [PROD2_W-1:0]  prod2_t;
    typedef logic signed [M_W-1:0]      m_t;
    typedef logic signed [SUM2_W-1:0]   sum2_t;

    typedef struct packed {
        c0_t c0;    // top field
        c1_t c1;
        c2_t c2;
    } coef_row_t;

endpackage

/* src/gng_seg_pkg.sv */
package gng_seg_pkg;

    localparam int LZD_W   = 16;    // top bits searched for leading zeros
    localparam int NUM_SEG = 16;
    localparam int SEG_W   = $clog2(NUM_SEG);
    localparam int OFS_W   = 2;     // sub-segment bits
    localparam int ADDR_W  = SEG_W + OFS_W;

    localparam int    TABLE_DEPTH = 2 ** ADDR_W;
    localparam string COEF_FILE   = "src/gng_coef.hex";

    // field positions in the random word
    localparam int SIGN_BIT   = 0;
    localparam int OFS_HI_BIT = 1;
    localparam int OFS_LO_BIT = 2;
    localparam int X_LSB      = 3;  // holds the msb of x

    localparam int SEG_LAT   = 1;
    localparam int ROM_LAT   = 1;
    localparam int POLY_LAT  = 7;
    localparam int OUT_LAT   = 1;
    localparam int TOTAL_LAT = SEG_LAT + ROM_LAT + POLY_LAT + OUT_LAT;

    typedef logic [SEG_W-1:0]  seg_t;
    typedef logic [OFS_W-1:0]  ofs_t;
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

/* src/gng_delay.sv */
module gng_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  payload_t din,
    output payload_t dout
);

    payload_t pipe [DEPTH];

    always_ff @(posedge clk) begin
        pipe[0] <= din;
        for (int k = 1; k < DEPTH; k++) begin
            pipe[k] <= pipe[k-1];
        end
    end

    assign dout = pipe[DEPTH-1];

endmodule

/* src/gng_segment.sv */
module gng_segment
    import gng_num_pkg::*, gng_seg_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  valid_in,
    input  urng_t data_in,
    output addr_t seg_addr,
    output x_t    x,
    output logic  sign,
    output logic  seg_valid
);

    localparam int CNT_W = $clog2(LZD_W + 1);

    logic [LZD_W-1:0] zero_run;    // bit i set when the top i+1 bits are zero
    logic [CNT_W-1:0] lz_cnt;
    seg_t             seg;
    ofs_t             ofs;
    x_t               x_c;

    genvar i;
    generate
        for (i = 0; i < LZD_W; i++) begin : g_run
            if (i == 0) begin : g_top
                assign zero_run[i] = ~data_in[URNG_W-1];
            end else begin : g_next
                assign zero_run[i] = zero_run[i-1] & ~data_in[URNG_W-1-i];
            end
        end

        // x field is stored lsb first in the word
        for (i = 0; i < X_W; i++) begin : g_xrev
            assign x_c[X_W-1-i] = data_in[X_LSB+i];
        end
    endgenerate

    // run bits form a thermometer code, so their count is the lz count
    always_comb begin
        lz_cnt = '0;
        for (int k = 0; k < LZD_W; k++) begin
            lz_cnt = lz_cnt + CNT_W'(zero_run[k]);
        end
    end

    // all-zero top word falls back to the last kept segment
    assign seg = (lz_cnt > CNT_W'(NUM_SEG - 1)) ? seg_t'(NUM_SEG - 1)
                                                : lz_cnt[SEG_W-1:0];

    assign ofs = {data_in[OFS_HI_BIT], data_in[OFS_LO_BIT]};

    always_ff @(posedge clk) begin
        seg_addr <= {seg, ofs};
        x        <= x_c;
        sign     <= data_in[SIGN_BIT];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            seg_valid <= 1'b0;
        end else begin
            seg_valid <= valid_in;
        end
    end

endmodule

/* src/gng_coef_rom.sv */
module gng_coef_rom
    import gng_num_pkg::*, gng_seg_pkg::*;
(
    input  logic  clk,
    input  addr_t seg_addr,
    output c0_t   c0,
    output c1_t   c1,
    output c2_t   c2
);

    coef_row_t rom [TABLE_DEPTH];   // {c0, c1, c2} per row

    initial begin
        $readmemh(COEF_FILE, rom);
    end

    always_ff @(posedge clk) begin
        c0 <= rom[seg_addr].c0;
        c1 <= rom[seg_addr].c1;
        c2 <= rom[seg_addr].c2;
    end

endmodule

/* src/gng_poly_eval.sv */
module gng_poly_eval
    import gng_num_pkg::*;
(
    input  logic clk,
    input  x_t   x,
    input  c0_t  c0,
    input  c1_t  c1,
    input  c2_t  c2,
    output mag_t mag
);

    x_t     x_al;       // lined up with the coefficients
    x_t     x_mul2;     // lined up with t
    c0_t    c0_d;       // lined up with m
    x_t     a1;
    c2_t    b1;
    c1_t    c1_q1;
    c1_t    c1_q2;
    prod1_t prod1;
    sum1_t  c1_ext;
    sum1_t  prod1_ext;
    sum1_t  sum1;
    t_t     t;
    x_t     a2;
    t_t     b2;
    prod2_t prod2;
    m_t     m;
    sum2_t  sum2;

    gng_delay #(.payload_t(x_t), .DEPTH(1)) x_al_dly_i (
        .clk  (clk),
        .din  (x),
        .dout (x_al)
    );

    gng_delay #(.payload_t(x_t), .DEPTH(3)) x_mul2_dly_i (
        .clk  (clk),
        .din  (x_al),
        .dout (x_mul2)
    );

    gng_delay #(.payload_t(c0_t), .DEPTH(5)) c0_dly_i (
        .clk  (clk),
        .din  (c0),
        .dout (c0_d)
    );

    // first multiply-add x*c2 + c1*2^19
    always_ff @(posedge clk) begin
        a1    <= x_al;
        b1    <= c2;
        c1_q1 <= c1;
    end

    always_ff @(posedge clk) begin
        prod1 <= a1 * b1;   // both unsigned
        c1_q2 <= c1_q1;     // keeps c1 in step with prod1
    end

    assign c1_ext    = {{(SUM1_W - C1_W - C1_SHIFT){c1_q2[C1_W-1]}}, c1_q2,
                        {C1_SHIFT{1'b0}}};
    assign prod1_ext = {{(SUM1_W - PROD1_W){1'b0}}, prod1};

    always_ff @(posedge clk) begin
        sum1 <= c1_ext + prod1_ext;
    end

    assign t = sum1[T_LSB +: T_W];   // s<18,18>

    // second multiply x*t
    always_ff @(posedge clk) begin
        a2 <= x_mul2;
        b2 <= t;
    end

    always_ff @(posedge clk) begin
        prod2 <= $signed({1'b0, a2}) * b2;
    end

    assign m = prod2[M_LSB +: M_W];   // s<14,14>

    always_ff @(posedge clk) begin
        sum2 <= $signed({1'b0, c0_d}) + m;   // s<19,14>
    end

    // round half up at bit 2
    always_ff @(posedge clk) begin
        mag <= sum2[RND_LSB +: MAG_W] + MAG_W'(sum2[RND_LSB-1]);
    end

endmodule

/* src/gng_sign_out.sv */
module gng_sign_out
    import gng_num_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  mag_t    mag,
    input  logic    sign,
    input  logic    valid,
    output logic    valid_out,
    output sample_t data_out
);

    sample_t mag_ext;
    sample_t sample;

    assign mag_ext = {1'b0, mag};
    assign sample  = sign ? sample_t'(~mag_ext + 1'b1) : mag_ext;   // two's complement

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_out <= 1'b0;
            data_out  <= '0;
        end else begin
            valid_out <= valid;
            if (valid) begin
                data_out <= sample;   // holds last sample between strobes
            end
        end
    end

endmodule

/* src/gng_interp.sv */
module gng_interp
    import gng_num_pkg::*, gng_seg_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  logic    valid_in,
    input  urng_t   data_in,
    output logic    valid_out,
    output sample_t data_out
);

    addr_t seg_addr;
    x_t    x;
    logic  sign;
    logic  seg_valid;
    c0_t   c0;
    c1_t   c1;
    c2_t   c2;
    mag_t  mag;
    logic  sign_d;
    logic  valid_d;

    gng_segment segment_i (
        .clk       (clk),
        .rstn      (rstn),
        .valid_in  (valid_in),
        .data_in   (data_in),
        .seg_addr  (seg_addr),
        .x         (x),
        .sign      (sign),
        .seg_valid (seg_valid)
    );

    gng_coef_rom coef_rom_i (
        .clk      (clk),
        .seg_addr (seg_addr),
        .c0       (c0),
        .c1       (c1),
        .c2       (c2)
    );

    gng_poly_eval poly_eval_i (
        .clk (clk),
        .x   (x),
        .c0  (c0),
        .c1  (c1),
        .c2  (c2),
        .mag (mag)
    );

    // sign and valid ride alongside the table read and polynomial
    gng_delay #(.payload_t(logic), .DEPTH(ROM_LAT + POLY_LAT)) sign_dly_i (
        .clk  (clk),
        .din  (sign),
        .dout (sign_d)
    );

    gng_delay #(.payload_t(logic), .DEPTH(ROM_LAT + POLY_LAT)) valid_dly_i (
        .clk  (clk),
        .din  (seg_valid),
        .dout (valid_d)
    );

    gng_sign_out sign_out_i (
        .clk       (clk),
        .rstn      (rstn),
        .mag       (mag),
        .sign      (sign_d),
        .valid     (valid_d),
        .valid_out (valid_out),
        .data_out  (data_out)
    );

endmodule

/* dv/gng_interp_tb.sv */
module gng_interp_tb
    import gng_num_pkg::*, gng_seg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          DRIVE_DLY  = 10;
    localparam int          N_BURST    = 200;
    localparam int          N_GAPPED   = 200;
    localparam int          N_ZPAIR    = 4;
    localparam int          N_SPAIR    = 8;
    localparam int          ZP_TAGS    = 2 * N_ZPAIR;
    localparam int          N_TAGS     = ZP_TAGS + 2 * N_SPAIR;
    localparam int          MAX_CYCLES = 2000;   // ~600 inputs with gaps, drains, margin
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam logic [31:0] LFSR_SEED  = 32'd95875;

    typedef struct packed {
        int      due;   // cycle in which the sample should show
        sample_t smp;
        int      tag;
    } exp_item_t;

    logic    clk;
    logic    rstn;
    logic    valid_in;
    urng_t   data_in;
    logic    valid_out;
    sample_t data_out;

    int          cyc = 0;
    logic [31:0] lfsr_state = LFSR_SEED;
    logic [52:0] coef_mem [TABLE_DEPTH];
    exp_item_t   exp_q [$];
    logic        exp_valid = 1'b0;
    sample_t     exp_data = '0;
    int          exp_tag = -1;
    logic        out_started = 1'b0;
    logic        check_en = 1'b0;
    sample_t     obs [N_TAGS];

    gng_interp dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .valid_in  (valid_in),
        .data_in   (data_in),
        .valid_out (valid_out),
        .data_out  (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [63:0] take_bits(int n);
        logic [63:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[62:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // random shift spreads words over the segments
    function automatic urng_t random_word();
        urng_t       w;
        logic [63:0] sh;
        w  = take_bits(64);
        sh = take_bits(4);
        return w >> sh[3:0];
    endfunction

    function automatic sample_t model_sample(urng_t w);
        int          lz;
        int          i;
        seg_t        seg;
        ofs_t        sub;
        x_t          xv;
        logic [52:0] row;
        longint      c0v;
        longint      c1v;
        longint      c2v;
        longint      s1;
        longint      tv;
        longint      p2;
        longint      mv;
        longint      sv;
        longint      magv;
        lz = 0;
        while (lz < LZD_W && w[URNG_W-1-lz] == 1'b0) begin
            lz++;
        end
        if (lz > NUM_SEG - 1) begin
            lz = NUM_SEG - 1;   // far tail folds into the last segment
        end
        seg = seg_t'(lz);
        sub = {w[1], w[2]};
        for (i = 0; i < 15; i++) begin
            xv[14-i] = w[3+i];
        end
        row = coef_mem[{seg, sub}];
        c0v = longint'(row[52:35]);
        c1v = longint'($signed(row[34:17]));
        c2v = longint'(row[16:0]);
        s1  = longint'(xv) * c2v + c1v * 524288;
        tv  = (s1 >>> 20) & 'h3FFFF;   // bits 37..20
        if (tv >= 'h20000) begin
            tv = tv - 'h40000;
        end
        p2 = longint'(xv) * tv;
        mv = (p2 >>> 19) & 'h3FFF;     // bits 32..19
        if (mv >= 'h2000) begin
            mv = mv - 'h4000;
        end
        sv   = c0v + mv;
        magv = (((sv >>> 3) & 'h7FFF) + ((sv >>> 2) & 1)) & 'h7FFF;
        if (w[0]) begin
            return sample_t'(-magv);
        end
        return sample_t'(magv);
    endfunction

    // expected outputs for this clock, then the next input word
    task automatic drive_cycle(input logic v, input urng_t w, input int tag);
        exp_item_t item;
        @(posedge clk);
        #DRIVE_DLY;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            exp_valid   = 1'b1;
            exp_data    = exp_q[0].smp;
            exp_tag     = exp_q[0].tag;
            out_started = 1'b1;
            void'(exp_q.pop_front());
        end else begin
            exp_valid = 1'b0;
            exp_tag   = -1;
        end
        valid_in = v;
        data_in  = w;
        if (v) begin
            item.due = cyc + TOTAL_LAT;
            item.smp = model_sample(w);
            item.tag = tag;
            exp_q.push_back(item);
        end
    endtask

    // outputs settle on posedge, so look at them on negedge
    valid_out_chk: assert property (@(negedge clk) disable iff (!check_en)
        valid_out == exp_valid)
    else begin
        $display("error valid_out expected %h got %h", exp_valid, valid_out);
        stop_run();
    end

    data_out_chk: assert property (@(negedge clk) disable iff (!check_en)
        exp_valid |-> data_out == exp_data)
    else begin
        $display("error data_out expected %h got %h", exp_data, data_out);
        stop_run();
    end

    idle_out_chk: assert property (@(negedge clk) disable iff (!check_en)
        !out_started |-> data_out == '0)
    else begin
        $display("error data_out expected %h got %h", 16'h0000, data_out);
        stop_run();
    end

    always @(negedge clk) begin
        if (check_en && exp_valid && exp_tag >= 0) begin
            obs[exp_tag] = data_out;
        end
    end

    task automatic check_clamp_pairs();
        int k;
        for (k = 0; k < N_ZPAIR; k++) begin
            assert (obs[2*k] == obs[2*k+1])
            else begin
                $display("error data_out expected %h got %h", obs[2*k], obs[2*k+1]);
                stop_run();
            end
        end
    endtask

    task automatic check_sign_pairs();
        int k;
        int a;
        for (k = 0; k < N_SPAIR; k++) begin
            a = ZP_TAGS + 2 * k;
            assert (sample_t'(obs[a] + obs[a+1]) == '0)
            else begin
                $display("error data_out expected %h got %h", sample_t'(-obs[a]), obs[a+1]);
                stop_run();
            end
        end
    endtask

    initial begin
        urng_t       w;
        logic [63:0] low;
        logic [63:0] mid;
        ofs_t        sub;
        int          k;
        int          j;
        rstn     = 1'b0;
        valid_in = 1'b0;
        data_in  = '0;
        $readmemh(COEF_FILE, coef_mem);
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rstn     = 1'b1;
        check_en = 1'b1;

        for (k = 0; k < N_BURST; k++) begin
            drive_cycle(1'b1, random_word(), -1);
        end
        for (k = 0; k < N_GAPPED; k++) begin
            if (take_bits(2) == 0) begin
                drive_cycle(1'b0, take_bits(64), -1);   // idle data is don't care
            end
            drive_cycle(1'b1, random_word(), -1);
        end

        // every leading-zero count with every sub-segment
        for (k = 0; k < NUM_SEG; k++) begin
            for (j = 0; j < 4; j++) begin
                sub = ofs_t'(j);
                w   = take_bits(64);
                w   = (w >> (k + 1)) | (64'h8000_0000_0000_0000 >> k);
                w[1] = sub[1];
                w[2] = sub[0];
                drive_cycle(1'b1, w, -1);
            end
        end

        // 15 leading zeros against an all-zero top, same low 18 bits
        for (k = 0; k < N_ZPAIR; k++) begin
            low = take_bits(18);
            mid = take_bits(30);
            drive_cycle(1'b1, {16'h0001, mid[29:0], low[17:0]}, 2 * k);
            mid = take_bits(30);
            drive_cycle(1'b1, {16'h0000, mid[29:0], low[17:0]}, 2 * k + 1);
        end

        for (k = 0; k < N_SPAIR; k++) begin
            w = random_word();
            drive_cycle(1'b1, {w[63:1], 1'b0}, ZP_TAGS + 2 * k);
            drive_cycle(1'b1, {w[63:1], 1'b1}, ZP_TAGS + 2 * k + 1);
        end

        while (exp_q.size() > 0) begin
            drive_cycle(1'b0, '0, -1);
        end
        repeat (2) drive_cycle(1'b0, '0, -1);

        check_clamp_pairs();
        check_sign_pairs();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* src/gng_coef.hex */
// row address {segment, sub-segment}; columns c0 u18 [52:35], c1 s18 [34:17], c2 u17 [16:0]
// values packed into one 53-bit word per row
001007F0000300
004000E0000310
007000E0000320
00A000E0000330
00F00080000400
01000080000410
01100080000420
01200080000430
01400060000500
014C0060000510
01580060000520
01640060000530
01800050000600
018A0050000610
01940050000620
019E0050000630
01B00040000700
01B80040000710
01C00040000720
01C80040000730
01D80038000800
01DF0038000810
01E60038000820
01ED0038000830
01F80030000900
01FE0030000910
02040030000920
020A0030000930
02180028000A00
021D0028000A10
02220028000A20
02270028000A30
02300028000B00
02350028000B10
023A0028000B20
023F0028000B30
02480024000C00
024C8024000C10
02510024000C20
02558024000C30
02600020000D00
02640020000D10
02680020000D20
026C0020000D30
02740020000E00
02780020000E10
027C0020000E20
02800020000E30
0288001C000F00
028B801C000F10
028F001C000F20
0292801C000F30
0298001C001000
029B801C001010
029F001C001020
02A2801C001030
02A80018001100
02AB0018001110
02AE0018001120
02B10018001130
02B80018001200
02BB0018001210
02BE0018001220
02C10018001230

/* tb.f */
src/gng_num_pkg.sv
src/gng_seg_pkg.sv
src/gng_delay.sv
src/gng_segment.sv
src/gng_coef_rom.sv
src/gng_poly_eval.sv
src/gng_sign_out.sv
src/gng_interp.sv
dv/gng_interp_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal -j 0 \
    --top-module gng_interp_tb -f tb.f -o gng_interp_sim

./obj_dir/gng_interp_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
